// File: verilog.f
+incdir+.
predecodePkg.sv
parcelClassifier.sv
boundaryScan.sv
slotCompactor.sv
jumpSelector.sv
predecoder.sv
predecoderTb.sv

// File: run.sh
#!/bin/sh
# build and run the predecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module predecoderTb \
  -f verilog.f -o predecoderSim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/predecoderSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1

// File: predecoderModel.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the bundle predecoder, included inside the
// testbench module. buildExpected fills the exp* state from one
// bundle and its start offset.
//////////////////////////////////////////////////////////////////////
`ifndef PREDECODER_MODEL_SVH
`define PREDECODER_MODEL_SVH

logic [63:0] expInstr [NUM_SLOTS];
logic [3:0]  expOff [NUM_SLOTS];
logic [2:0]  expLen [NUM_SLOTS];
logic [7:0]  expClass [NUM_SLOTS];
logic [NUM_SLOTS-1:0]      expEn;
logic [2:0]                expJumpSlot [NUM_JUMP_SLOTS];
logic [NUM_JUMP_SLOTS-1:0] expJumpEn;
logic expHasJumps;
logic expError;
logic expJerror;

task automatic clearExpected();
  for (int s = 0; s < NUM_SLOTS; s++) begin
    expInstr[s] = '0;
    expOff[s]   = '0;
    expLen[s]   = '0;
    expClass[s] = '0;
  end
  for (int j = 0; j < NUM_JUMP_SLOTS; j++) begin
    expJumpSlot[j] = '0;
  end
  expEn       = '0;
  expJumpEn   = '0;
  expHasJumps = 1'b0;
  expError    = 1'b0;
  expJerror   = 1'b0;
endtask

// opcode map, short form for one parcel, main form otherwise
function automatic logic [7:0] expectedClass(input logic [15:0] first, input int len);
  logic [7:0] cls;
  int         op;
  cls = '0;
  if (len == 1) begin
    op = int'(first[5:0]);
    if (op <= 19)
      cls[predecodePkg::CLS_ALU] = 1'b1;
    else if (op >= 21 && op <= 31 && op % 2 == 1)
      cls[predecodePkg::CLS_SHIFT] = 1'b1;
    else if (op >= 48 && op <= 51)
      cls[predecodePkg::CLS_JUMP] = 1'b1;
    else if (op >= 52)
      cls[predecodePkg::CLS_FPU] = 1'b1;
  end else begin
    op = int'(first[7:0]);
    if (op <= 39) begin
      if (op % 8 >= 4)
        cls[predecodePkg::CLS_MUL] = 1'b1;
      else
        cls[predecodePkg::CLS_ALU] = 1'b1;
    end else if (op <= 45) begin
      cls[predecodePkg::CLS_SHIFT] = 1'b1;
    end else if (op <= 53) begin
      cls[predecodePkg::CLS_ALU] = 1'b1;   // compare
    end else if (op >= 64 && op <= 159) begin
      if (op % 2 == 1)
        cls[predecodePkg::CLS_STORE] = 1'b1;
      else
        cls[predecodePkg::CLS_LOAD] = 1'b1;
    end else if (op >= 160 && op <= 175) begin
      cls[predecodePkg::CLS_JUMP] = 1'b1;
      cls[predecodePkg::CLS_ALU]  = 1'b1;
    end else if (op >= 176 && op <= 182) begin
      cls[predecodePkg::CLS_JUMP] = 1'b1;
    end else if (op == 240) begin
      cls[predecodePkg::CLS_FPU] = 1'b1;
    end else if (op == 255) begin
      cls[predecodePkg::CLS_SYS] = 1'b1;
    end
  end
  return cls;
endfunction

task automatic buildExpected(input logic [255:0] b, input logic [3:0] off);
  logic [14:0] marks;
  logic        isStart;
  int          n;
  int          nJump;
  int          len;
  marks = b[254:240];
  n     = 0;
  nJump = 0;
  clearExpected();
  expError = (off == 4'd15);
  for (int k = 0; k < 15; k++) begin
    isStart = (k >= int'(off)) && ((k == 0) ? 1'b1 : marks[k-1]);
    if (isStart) begin
      len = 0;
      for (int d = 3; d >= 0; d--) begin
        if (k + d < 15 && marks[k + d])
          len = d + 1;   // nearest end wins
      end
      if (len == 0)
        expError = 1'b1;
      if (n < NUM_SLOTS) begin
        expEn[n]    = 1'b1;
        expOff[n]   = 4'(k);
        expLen[n]   = 3'(len);
        expClass[n] = expectedClass(b[k*16 +: 16], len);
        for (int p = 0; p < len; p++) begin
          expInstr[n][p*16 +: 16] = b[(k+p)*16 +: 16];
        end
      end
      n++;
    end
  end
  if (n > NUM_SLOTS)
    expError = 1'b1;
  for (int s = 0; s < NUM_SLOTS; s++) begin
    if (expEn[s] && expClass[s][predecodePkg::CLS_JUMP]) begin
      if (nJump < NUM_JUMP_SLOTS) begin
        expJumpSlot[nJump] = 3'(s);
        expJumpEn[nJump]   = 1'b1;
      end
      nJump++;
    end
  end
  expHasJumps = (nJump > 0);
  expJerror   = (nJump > NUM_JUMP_SLOTS);
endtask

`endif

// File: predecoderTb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the bundle predecoder. Feeds random bundles with a
// random valid strobe and checks every registered output against
// the reference model one rising edge later.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module predecoderTb;

  localparam int          NUM_SLOTS      = 8;
  localparam int          NUM_JUMP_SLOTS = 4;
  localparam int          NUM_BUNDLES    = 2000;
  localparam int          PERIOD         = 20;   // ns
  localparam logic [31:0] SEED           = 32'h2ffa_3f7b;

  logic                      clk;
  logic                      rstN;
  logic                      bundleValid;
  logic [255:0]              bundle;
  logic [3:0]                startOff;
  logic                      outValid;
  logic [63:0]               slotInstr [NUM_SLOTS];
  logic [3:0]                slotOff [NUM_SLOTS];
  logic [2:0]                slotLen [NUM_SLOTS];
  logic [7:0]                slotClass [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]      slotEn;
  logic [2:0]                jumpSlot [NUM_JUMP_SLOTS];
  logic [NUM_JUMP_SLOTS-1:0] jumpEn;
  logic                      hasJumps;
  logic                      error;
  logic                      jerror;

  int   errorCount;
  int   checkCount;
  logic expOutValid;
  logic haveResult;   // set by the first accepted bundle

  `include "predecoderModel.svh"

  predecoder #(.numSlots(NUM_SLOTS), .numJumpSlots(NUM_JUMP_SLOTS)) dut_i (
    .clk         (clk),
    .rstN        (rstN),
    .bundleValid (bundleValid),
    .bundle      (bundle),
    .startOff    (startOff),
    .outValid    (outValid),
    .slotInstr   (slotInstr),
    .slotOff     (slotOff),
    .slotLen     (slotLen),
    .slotClass   (slotClass),
    .slotEn      (slotEn),
    .jumpSlot    (jumpSlot),
    .jumpEn      (jumpEn),
    .hasJumps    (hasJumps),
    .error       (error),
    .jerror      (jerror)
  );

  always #(PERIOD/2) clk = ~clk;

  task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                input logic [63:0] gotVal);
    errorCount++;
    $display("error at time %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
  endtask

  task automatic checkOutputs();
    checkCount++;
    if (outValid !== expOutValid)
      reportMismatch("outValid", 64'(expOutValid), 64'(outValid));
    if (slotEn !== expEn)
      reportMismatch("slotEn", 64'(expEn), 64'(slotEn));
    if (jumpEn !== expJumpEn)
      reportMismatch("jumpEn", 64'(expJumpEn), 64'(jumpEn));
    if (hasJumps !== expHasJumps)
      reportMismatch("hasJumps", 64'(expHasJumps), 64'(hasJumps));
    if (error !== expError)
      reportMismatch("error", 64'(expError), 64'(error));
    if (jerror !== expJerror)
      reportMismatch("jerror", 64'(expJerror), 64'(jerror));
    if (haveResult) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (slotInstr[s] !== expInstr[s])
          reportMismatch($sformatf("slotInstr[%0d]", s), expInstr[s], slotInstr[s]);
        if (slotOff[s] !== expOff[s])
          reportMismatch($sformatf("slotOff[%0d]", s), 64'(expOff[s]), 64'(slotOff[s]));
        if (slotLen[s] !== expLen[s])
          reportMismatch($sformatf("slotLen[%0d]", s), 64'(expLen[s]), 64'(slotLen[s]));
        if (slotClass[s] !== expClass[s])
          reportMismatch($sformatf("slotClass[%0d]", s), 64'(expClass[s]),
                         64'(slotClass[s]));
      end
      for (int j = 0; j < NUM_JUMP_SLOTS; j++) begin
        if (jumpSlot[j] !== expJumpSlot[j])
          reportMismatch($sformatf("jumpSlot[%0d]", j), 64'(expJumpSlot[j]),
                         64'(jumpSlot[j]));
      end
    end
  endtask

  // mostly legal lengths, rare wide gaps, some all-short bundles
  task automatic makeBundle(output logic [255:0] b, output logic [3:0] off);
    int pos;
    int len;
    int mode;
    for (int w = 0; w < 8; w++) begin
      b[w*32 +: 32] = $urandom;
    end
    b[254:240] = '0;
    for (int k = 0; k < 15; k++) begin
      if ($urandom % 4 == 0)
        b[k*16 +: 8] = 8'(160 + $urandom % 23);   // push jumps in
    end
    mode = int'($urandom % 10);
    pos  = 0;
    while (pos < 15) begin
      if (mode == 0)
        len = 1;
      else if ($urandom % 25 == 0)
        len = 5;
      else
        len = 1 + int'($urandom % 4);
      pos = pos + len;
      if (pos > 15 && len < 5)
        pos = 15;
      if (pos <= 15)
        b[240 + pos - 1] = 1'b1;
    end
    mode = int'($urandom % 10);
    if (mode < 6)
      off = 4'd0;
    else if (mode < 9)
      off = 4'($urandom % 15);
    else
      off = 4'(13 + $urandom % 3);
  endtask

  initial begin
    logic [255:0] nextBundle;
    logic [3:0]   nextOff;
    logic         nextValid;
    clk         = 1'b0;
    rstN        = 1'b0;
    bundleValid = 1'b0;
    bundle      = '0;
    startOff    = '0;
    errorCount  = 0;
    checkCount  = 0;
    expOutValid = 1'b0;
    haveResult  = 1'b0;
    void'($urandom(SEED));
    clearExpected();
    // a bundle held valid through reset must not reach the outputs
    makeBundle(nextBundle, nextOff);
    bundle      = nextBundle;
    bundleValid = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkOutputs();   // state straight out of reset
    for (int i = 0; i < NUM_BUNDLES; i++) begin
      makeBundle(nextBundle, nextOff);
      nextValid   = ($urandom % 4) != 0;
      bundleValid = nextValid;
      bundle      = nextBundle;
      startOff    = nextOff;
      if (nextValid) begin
        buildExpected(nextBundle, nextOff);
        haveResult = 1'b1;
      end
      expOutValid = nextValid;
      @(negedge clk);
      checkOutputs();
    end
    bundleValid = 1'b0;
    $display("checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // twice the stimulus length plus some slack
  initial begin
    #((NUM_BUNDLES * 2 + 50) * PERIOD);
    $display("timeout: the run did not reach its end in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: predecoder.sv
//////////////////////////////////////////////////////////////////////
// Bundle predecoder top level. Splits a 256-bit bundle into parcels
// and end markers, decodes it in one combinational pass and loads
// the result into the output register when bundleValid is high.
// outValid pulses for the cycle after each accepted bundle.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module predecoder #(
  parameter int numSlots     = 8,
  parameter int numJumpSlots = 4
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             bundleValid,
  input  logic [255:0]                     bundle,       // bit 255 unused
  input  logic [3:0]                       startOff,
  output logic                             outValid,
  output logic [predecodePkg::INSTR_W-1:0] slotInstr [numSlots],
  output logic [3:0]                       slotOff [numSlots],
  output logic [2:0]                       slotLen [numSlots],
  output logic [predecodePkg::CLASS_W-1:0] slotClass [numSlots],
  output logic [numSlots-1:0]              slotEn,
  output logic [2:0]                       jumpSlot [numJumpSlots],
  output logic [numJumpSlots-1:0]          jumpEn,
  output logic                             hasJumps,
  output logic                             error,
  output logic                             jerror
);
  import predecodePkg::*;

  logic [PARCEL_W-1:0]             parcels [NUM_PARCELS];
  logic [(NUM_PARCELS+1)*PARCEL_W-1:0] parcelPad;
  instrWordT                       classWord [NUM_PARCELS];
  logic [NUM_PARCELS-1:0]          startFlag;
  logic [2:0]                      instrLen [NUM_PARCELS];
  logic [3:0]                      ordinal [NUM_PARCELS];
  logic [CLASS_W-1:0]              instrClass [NUM_PARCELS];
  logic                            errorComb;

  logic [INSTR_W-1:0]              slotInstrComb [numSlots];
  logic [3:0]                      slotOffComb [numSlots];
  logic [2:0]                      slotLenComb [numSlots];
  logic [CLASS_W-1:0]              slotClassComb [numSlots];
  logic [numSlots-1:0]             slotEnComb;
  logic [2:0]                      jumpSlotComb [numJumpSlots];
  logic [numJumpSlots-1:0]         jumpEnComb;
  logic                            hasJumpsComb;
  logic                            jerrorComb;

  // zero parcel above the last so the top classifier sees a full word
  assign parcelPad = {{PARCEL_W{1'b0}}, bundle[NUM_PARCELS*PARCEL_W-1:0]};

  boundaryScan #(.numSlots(numSlots)) uScan (
    .endMarks  (bundle[NUM_PARCELS*PARCEL_W +: NUM_PARCELS]),
    .startOff  (startOff),
    .startFlag (startFlag),
    .instrLen  (instrLen),
    .ordinal   (ordinal),
    .errorComb (errorComb)
  );

  for (genvar k = 0; k < NUM_PARCELS; k++) begin : genParcel
    assign parcels[k]   = bundle[k*PARCEL_W +: PARCEL_W];
    assign classWord[k] = parcelPad[k*PARCEL_W +: 2*PARCEL_W];

    parcelClassifier uCls (
      .word       (classWord[k]),
      .instrLen   (instrLen[k]),
      .instrClass (instrClass[k])
    );
  end

  slotCompactor #(.numSlots(numSlots)) uCompact (
    .parcels    (parcels),
    .startFlag  (startFlag),
    .ordinal    (ordinal),
    .instrLen   (instrLen),
    .instrClass (instrClass),
    .slotInstr  (slotInstrComb),
    .slotOff    (slotOffComb),
    .slotLen    (slotLenComb),
    .slotClass  (slotClassComb),
    .slotEn     (slotEnComb)
  );

  jumpSelector #(.numSlots(numSlots), .numJumpSlots(numJumpSlots)) uJump (
    .slotEn    (slotEnComb),
    .slotClass (slotClassComb),
    .jumpSlot  (jumpSlotComb),
    .jumpEn    (jumpEnComb),
    .hasJumps  (hasJumpsComb),
    .jerror    (jerrorComb)
  );

  // payload, held until the next accepted bundle
  always_ff @(posedge clk) begin
    if (bundleValid) begin
      slotInstr <= slotInstrComb;
      slotOff   <= slotOffComb;
      slotLen   <= slotLenComb;
      slotClass <= slotClassComb;
      jumpSlot  <= jumpSlotComb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      slotEn   <= '0;
      jumpEn   <= '0;
      hasJumps <= 1'b0;
      error    <= 1'b0;
      jerror   <= 1'b0;
    end else begin
      outValid <= bundleValid;   // one-cycle pulse per accept
      if (bundleValid) begin
        slotEn   <= slotEnComb;
        jumpEn   <= jumpEnComb;
        hasJumps <= hasJumpsComb;
        error    <= errorComb;
        jerror   <= jerrorComb;
      end
    end
  end

endmodule

`default_nettype wire

// File: jumpSelector.sv
//////////////////////////////////////////////////////////////////////
// Lists the slot indexes of the first jumps in slot order, and
// flags when a bundle holds more jumps than the list can take.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jumpSelector #(
  parameter int numSlots     = 8,
  parameter int numJumpSlots = 4
) (
  input  logic [numSlots-1:0]              slotEn,
  input  logic [predecodePkg::CLASS_W-1:0] slotClass [numSlots],
  output logic [2:0]                       jumpSlot [numJumpSlots],
  output logic [numJumpSlots-1:0]          jumpEn,
  output logic                             hasJumps,
  output logic                             jerror
);
  import predecodePkg::*;

  localparam int CNT_W = $clog2(numSlots + 1);

  logic [CNT_W-1:0] jumpCount;

  // running jump count picks the list entry for each jump slot
  always_comb begin
    jumpCount = '0;
    jumpEn    = '0;
    for (int j = 0; j < numJumpSlots; j++) begin
      jumpSlot[j] = 3'd0;
    end
    for (int s = 0; s < numSlots; s++) begin
      if (slotEn[s] && slotClass[s][CLS_JUMP]) begin
        for (int j = 0; j < numJumpSlots; j++) begin
          if (jumpCount == CNT_W'(j)) begin
            jumpSlot[j] = 3'(s);
            jumpEn[j]   = 1'b1;
          end
        end
        jumpCount = jumpCount + 1'b1;
      end
    end
  end

  assign hasJumps = (jumpCount != '0);
  assign jerror   = (jumpCount > CNT_W'(numJumpSlots));

endmodule

`default_nettype wire

// File: slotCompactor.sv
//////////////////////////////////////////////////////////////////////
// Packs the numbered instruction starts into output slots. Slot i
// gets the start with ordinal i, its offset, length, class and
// parcels, with the tail past its length zeroed.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module slotCompactor #(
  parameter int numSlots = 8
) (
  input  logic [predecodePkg::PARCEL_W-1:0]    parcels [predecodePkg::NUM_PARCELS],
  input  logic [predecodePkg::NUM_PARCELS-1:0] startFlag,
  input  logic [3:0]                           ordinal [predecodePkg::NUM_PARCELS],
  input  logic [2:0]                           instrLen [predecodePkg::NUM_PARCELS],
  input  logic [predecodePkg::CLASS_W-1:0]     instrClass [predecodePkg::NUM_PARCELS],
  output logic [predecodePkg::INSTR_W-1:0]     slotInstr [numSlots],
  output logic [3:0]                           slotOff [numSlots],
  output logic [2:0]                           slotLen [numSlots],
  output logic [predecodePkg::CLASS_W-1:0]     slotClass [numSlots],
  output logic [numSlots-1:0]                  slotEn
);
  import predecodePkg::*;

  always_comb begin
    slotEn = '0;
    for (int s = 0; s < numSlots; s++) begin
      slotInstr[s] = '0;   // empty slots stay zero
      slotOff[s]   = 4'd0;
      slotLen[s]   = 3'd0;
      slotClass[s] = '0;
      for (int k = 0; k < NUM_PARCELS; k++) begin
        if (startFlag[k] && (ordinal[k] == 4'(s))) begin
          slotEn[s]    = 1'b1;
          slotOff[s]   = 4'(k);
          slotLen[s]   = instrLen[k];
          slotClass[s] = instrClass[k];
          for (int p = 0; p < MAX_LEN; p++) begin
            if ((3'(p) < instrLen[k]) && (k + p < NUM_PARCELS)) begin
              slotInstr[s][p*PARCEL_W +: PARCEL_W] = parcels[k + p];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: boundaryScan.sv
//////////////////////////////////////////////////////////////////////
// Instruction boundary search over the end markers of a bundle.
// Gives start flags, per-parcel lengths, the ordinal of every start
// and the combined error flag.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module boundaryScan #(
  parameter int numSlots = 8
) (
  input  logic [predecodePkg::NUM_PARCELS-1:0] endMarks,
  input  logic [3:0]                           startOff,
  output logic [predecodePkg::NUM_PARCELS-1:0] startFlag,
  output logic [2:0]                           instrLen [predecodePkg::NUM_PARCELS],
  output logic [3:0]                           ordinal [predecodePkg::NUM_PARCELS],
  output logic                                 errorComb
);
  import predecodePkg::*;

  logic [NUM_PARCELS+MAX_LEN-1:0] endPad;
  logic [NUM_PARCELS-1:0]         prevEnd;
  logic [4:0]                     startCount;
  logic                           badLen;

  assign endPad  = {{MAX_LEN{1'b0}}, endMarks};         // nothing ends past the bundle
  assign prevEnd = {endMarks[NUM_PARCELS-2:0], 1'b1};   // parcel 0 always begins one

  for (genvar k = 0; k < NUM_PARCELS; k++) begin : genStart
    assign startFlag[k] = prevEnd[k] && (4'(k) >= startOff);
  end

  // distance to the nearest end marker, 0 if none in reach
  always_comb begin
    for (int k = 0; k < NUM_PARCELS; k++) begin
      instrLen[k] = 3'd0;
      for (int d = MAX_LEN - 1; d >= 0; d--) begin
        if (endPad[k + d]) begin
          instrLen[k] = 3'(d + 1);
        end
      end
    end
  end

  // prefix count of starts
  always_comb begin
    startCount = 5'd0;
    badLen     = 1'b0;
    for (int k = 0; k < NUM_PARCELS; k++) begin
      ordinal[k] = startCount[3:0];
      if (startFlag[k]) begin
        startCount = startCount + 5'd1;
        if (instrLen[k] == 3'd0) begin
          badLen = 1'b1;   // gap wider than MAX_LEN
        end
      end
    end
  end

  assign errorComb = (startOff == 4'd15) || badLen || (startCount > 5'(numSlots));

endmodule

`default_nettype wire

// File: parcelClassifier.sv
//////////////////////////////////////////////////////////////////////
// Class decode of one instruction from its first two parcels.
// One-parcel instructions use the 6-bit short opcode, all longer
// ones the 8-bit main opcode. Several class bits may be set.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module parcelClassifier (
  input  predecodePkg::instrWordT                word,
  input  logic [2:0]                             instrLen,
  output logic [predecodePkg::CLASS_W-1:0]       instrClass
);
  import predecodePkg::*;

  logic [7:0] opMain;
  logic [5:0] opSub;
  logic       shortForm;

  logic subAlu;
  logic subShift;
  logic subJump;
  logic subFpu;

  logic isAluMul;
  logic isShift;
  logic isCmp;
  logic isMem;
  logic isCondJump;
  logic isJump;
  logic isFpu;
  logic isSys;

  assign opMain    = word.mainView.opcodeMain;
  assign opSub     = word.subView.opcodeSub;
  assign shortForm = (instrLen == 3'd1);

  // short opcode map
  assign subAlu   = (opSub <= OP_SUB_ALU_LAST);
  assign subShift = (opSub >= OP_SUB_SHIFT_FIRST) && (opSub <= OP_SUB_SHIFT_LAST) &&
                    opSub[0];
  assign subJump  = (opSub >= OP_SUB_JUMP_FIRST) && (opSub <= OP_SUB_JUMP_LAST);
  assign subFpu   = (opSub >= OP_SUB_FPU_FIRST);

  // main opcode map
  assign isAluMul   = (opMain <= OP_ALU_MUL_LAST);
  assign isShift    = (opMain >= OP_SHIFT_FIRST) && (opMain <= OP_SHIFT_LAST);
  assign isCmp      = (opMain >= OP_CMP_FIRST) && (opMain <= OP_CMP_LAST);
  assign isMem      = (opMain >= OP_MEM_FIRST) && (opMain <= OP_MEM_LAST);
  assign isCondJump = (opMain >= OP_COND_JUMP_BASE) && (opMain <= OP_COND_JUMP_LAST);
  assign isJump     = (opMain >= OP_JUMP_FIRST) && (opMain <= OP_INDIR_JUMP);
  assign isFpu      = (opMain == OP_FPU_SCALAR);
  assign isSys      = (opMain == OP_SYS);

  always_comb begin
    instrClass = '0;
    if (shortForm) begin
      instrClass[CLS_ALU]   = subAlu;
      instrClass[CLS_SHIFT] = subShift;
      instrClass[CLS_JUMP]  = subJump;
      instrClass[CLS_FPU]   = subFpu;
    end else begin
      instrClass[CLS_JUMP]  = isCondJump | isJump;
      // cond jumps also evaluate flags in the ALU
      instrClass[CLS_ALU]   = (isAluMul & ~opMain[2]) | isCmp | isCondJump;
      instrClass[CLS_MUL]   = isAluMul & opMain[2];
      instrClass[CLS_SHIFT] = isShift;
      instrClass[CLS_LOAD]  = isMem & ~opMain[0];
      instrClass[CLS_STORE] = isMem & opMain[0];
      instrClass[CLS_FPU]   = isFpu;
      instrClass[CLS_SYS]   = isSys;
    end
  end

endmodule

`default_nettype wire

// File: predecodePkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, class bit positions and opcode ranges of the
// bundle predecoder. RTL blocks import it inside the module body
// and use scoped names in their port lists.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package predecodePkg;

  localparam int PARCEL_W    = 16;
  localparam int NUM_PARCELS = 15;
  localparam int MAX_LEN     = 4;                   // parcels
  localparam int INSTR_W     = MAX_LEN * PARCEL_W;
  localparam int CLASS_W     = 8;

  // bit positions in the class vector
  localparam int CLS_JUMP  = 0;
  localparam int CLS_ALU   = 1;
  localparam int CLS_SHIFT = 2;
  localparam int CLS_MUL   = 3;
  localparam int CLS_LOAD  = 4;
  localparam int CLS_STORE = 5;
  localparam int CLS_FPU   = 6;
  localparam int CLS_SYS   = 7;

  // one-parcel forms, low 6 bits
  localparam logic [5:0] OP_SUB_ALU_LAST    = 6'd19;
  localparam logic [5:0] OP_SUB_SHIFT_FIRST = 6'd21;  // odd codes only
  localparam logic [5:0] OP_SUB_SHIFT_LAST  = 6'd31;
  localparam logic [5:0] OP_SUB_JUMP_FIRST  = 6'd48;
  localparam logic [5:0] OP_SUB_JUMP_LAST   = 6'd51;
  localparam logic [5:0] OP_SUB_FPU_FIRST   = 6'd52;  // up to 63

  // long forms, low 8 bits
  localparam logic [7:0] OP_ALU_MUL_LAST    = 8'd39;  // bit 2 selects mul
  localparam logic [7:0] OP_SHIFT_FIRST     = 8'd40;
  localparam logic [7:0] OP_SHIFT_LAST      = 8'd45;
  localparam logic [7:0] OP_CMP_FIRST       = 8'd46;
  localparam logic [7:0] OP_CMP_LAST        = 8'd53;
  localparam logic [7:0] OP_MEM_FIRST       = 8'd64;  // bit 0 selects store
  localparam logic [7:0] OP_MEM_LAST        = 8'd159;
  localparam logic [7:0] OP_COND_JUMP_BASE  = 8'd160;
  localparam logic [7:0] OP_COND_JUMP_LAST  = 8'd175;
  localparam logic [7:0] OP_JUMP_FIRST      = 8'd176;
  localparam logic [7:0] OP_INDIR_JUMP      = 8'd182; // last jump code
  localparam logic [7:0] OP_FPU_SCALAR      = 8'd240;
  localparam logic [7:0] OP_SYS             = 8'd255;

  typedef struct packed {
    logic [23:0] operands;
    logic [7:0]  opcodeMain;
  } mainViewT;

  typedef struct packed {
    logic [25:0] operands;
    logic [5:0]  opcodeSub;
  } subViewT;

  // first two parcels of an instruction, short and long decode
  typedef union packed {
    mainViewT mainView;
    subViewT  subView;
  } instrWordT;

endpackage

`default_nettype wire
